//--- rtl/mipsIsaPkg.sv
//////////////////////////////
// Instruction encodings and data-word types for the MEM stage
// Only the operations that the MEM stage tells apart are listed
// Cause codes follow the MIPS numbering, 0 also marks an interrupt
//////////////////////////////
`default_nettype none

package mipsIsaPkg;

    // Plain data and register widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [4:0]  excCode_t;
    typedef logic [5:0]  hwInt_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LW   = 4'd1,
        OP_LH   = 4'd2,
        OP_LHU  = 4'd3,
        OP_LB   = 4'd4,
        OP_LBU  = 4'd5,
        OP_SW   = 4'd6,
        OP_SH   = 4'd7,
        OP_SB   = 4'd8,
        OP_MFC0 = 4'd9,
        OP_MTC0 = 4'd10,
        OP_ERET = 4'd11,
        OP_ALU  = 4'd12
    } instrOp_t;

    typedef enum logic [2:0] {
        CLS_NONE  = 3'd0,
        CLS_MEM_R = 3'd1,
        CLS_MEM_W = 3'd2,
        CLS_CP0   = 3'd3,
        CLS_ALU   = 3'd4
    } instrClass_t;

    // Redirect request to the pipeline controller
    typedef enum logic [1:0] {
        KC_NONE  = 2'd0,
        KC_ENTRY = 2'd1,
        KC_ERET  = 2'd2
    } kernelCtrl_t;

    localparam excCode_t EXC_NONE = 5'd0;
    localparam excCode_t EXC_INT  = 5'd0;
    localparam excCode_t EXC_ADEL = 5'd4;
    localparam excCode_t EXC_ADES = 5'd5;
    localparam excCode_t EXC_OV   = 5'd12;

    // Coprocessor 0 register numbers
    localparam regAddr_t CP0_SR    = 5'd12;
    localparam regAddr_t CP0_CAUSE = 5'd13;
    localparam regAddr_t CP0_EPC   = 5'd14;
    localparam regAddr_t CP0_PRID  = 5'd15;

    localparam word_t PRID_VALUE = 32'h4D49_5053;

endpackage

`default_nettype wire

//--- rtl/memMapPkg.sv
//////////////////////////////
// Address map and bundles of the MEM stage
// Only the data window is a legal load or store target
// The memory is word addressed, byte lanes select the bytes written
//////////////////////////////
`default_nettype none

package memMapPkg;
    import mipsIsaPkg::*;

    typedef logic [29:0] wordAddr_t;
    typedef logic [1:0]  byteOffset_t;

    localparam word_t DM_ADDR_START = 32'h0000_0000;
    localparam word_t DM_ADDR_END   = 32'h0000_3000;
    localparam int unsigned DM_WORDS = 3072;
    localparam int unsigned DM_IDX_W = $clog2(DM_WORDS);

    // Kernel text base, EPC points here after reset
    localparam word_t KTEXT_START = 32'h0000_3000;

    typedef struct packed {
        wordAddr_t  wordAddr;
        logic [3:0] byteEn;
        word_t      wrData;
    } dmReq_t;

    typedef struct packed {
        instrOp_t    op;
        instrClass_t iclass;
        word_t       pc;
        excCode_t    exc;
        logic        delaySlot;
        word_t       aluResult;
        word_t       rtData;
        regAddr_t    rtNum;
        regAddr_t    rdNum;
        regAddr_t    destReg;
        word_t       destData;
    } memStageIn_t;

    // Raw word and offset, extension happens in write-back
    typedef struct packed {
        instrOp_t    op;
        instrClass_t iclass;
        word_t       pc;
        word_t       memWord;
        byteOffset_t offset;
        regAddr_t    destReg;
        word_t       destData;
    } wbStageOut_t;

endpackage

`default_nettype wire

//--- rtl/memAccessCheck.sv
//////////////////////////////
// Store lane decode and address checks, purely combinational
// Halfword and byte data are shifted onto their lanes here
// Lanes stay off while disabled or on an address fault
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module memAccessCheck import mipsIsaPkg::*, memMapPkg::*; (
    input  instrOp_t    op,
    input  instrClass_t iclass,
    input  word_t       addr,
    input  word_t       storeData,
    input  logic        dmDisable,
    output dmReq_t      dmReq,
    output byteOffset_t offset,
    output excCode_t    excCode
);

    logic       isLoad;
    logic       isStore;
    logic       isWordOp;
    logic       isHalfOp;
    logic       misaligned;
    logic       inWindow;
    logic [3:0] lanes;
    word_t      shiftedData;

    assign offset  = addr[1:0];
    assign isLoad  = (iclass == CLS_MEM_R);
    assign isStore = (iclass == CLS_MEM_W);

    assign isWordOp = (op == OP_LW) || (op == OP_SW);
    assign isHalfOp = (op == OP_LH) || (op == OP_LHU) || (op == OP_SH);

    // Bytes need no alignment
    assign misaligned = (isWordOp && (offset != 2'b00)) || (isHalfOp && offset[0]);

    // One unsigned compare covers both ends of the window
    assign inWindow = (addr - DM_ADDR_START) < (DM_ADDR_END - DM_ADDR_START);

    always_comb begin
        excCode = EXC_NONE;
        if (isLoad && (misaligned || !inWindow)) begin
            excCode = EXC_ADEL;
        end else if (isStore && (misaligned || !inWindow)) begin
            excCode = EXC_ADES;
        end
    end

    // Lane select and data placement
    always_comb begin
        lanes       = 4'b0000;
        shiftedData = storeData;
        if (isStore) begin
            case (op)
                OP_SW: begin
                    lanes = 4'b1111;
                end
                OP_SH: begin
                    lanes       = offset[1] ? 4'b1100 : 4'b0011;
                    shiftedData = storeData << {offset[1], 4'b0000};
                end
                OP_SB: begin
                    lanes       = 4'b0001 << offset;
                    shiftedData = storeData << {offset, 3'b000};
                end
                default: begin
                    lanes = 4'b0000;
                end
            endcase
        end
    end

    assign dmReq = '{
        wordAddr: addr[31:2],
        byteEn:   (dmDisable || (excCode != EXC_NONE)) ? 4'b0000 : lanes,
        wrData:   shiftedData
    };

endmodule

`default_nettype wire

//--- rtl/coprocessor0.sv
//////////////////////////////
// Coprocessor 0 with SR, Cause, EPC and PrID
// Entry wins over ERET and MTC0 in the same cycle
// Interrupts are masked while EXL is set or IE is clear
// PrID is read only
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module coprocessor0 import mipsIsaPkg::*, memMapPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  instrOp_t    op,
    input  regAddr_t    regNum,
    input  word_t       wrData,
    input  word_t       pc,
    input  logic        inDelaySlot,
    input  hwInt_t      hwInt,
    input  excCode_t    excIn,
    output kernelCtrl_t kCtrl,
    output logic        excInDelaySlot,
    output wordAddr_t   epc,
    output word_t       rdData
);

    // Status fields
    hwInt_t    intMask;
    logic      exl;
    logic      intEnable;

    // Cause fields
    hwInt_t    intPendingBits;
    excCode_t  causeCode;
    logic      branchDelay;

    wordAddr_t epcReg;

    logic      intPending;
    logic      excPending;
    logic      entry;
    word_t     entryPc;
    word_t     statusWord;
    word_t     causeWord;

    assign statusWord = {16'b0, intMask, 8'b0, exl, intEnable};
    assign causeWord  = {branchDelay, 15'b0, intPendingBits, 3'b0, causeCode, 2'b0};

    assign intPending = (|(intMask & hwInt)) && intEnable && !exl;
    assign excPending = (excIn != EXC_NONE);
    assign entry      = intPending || excPending;

    // Restart at the branch when the victim sits in its delay slot
    assign entryPc = inDelaySlot ? (pc - 32'd4) : pc;

    always_comb begin
        if (entry) begin
            kCtrl = KC_ENTRY;
        end else if (op == OP_ERET) begin
            kCtrl = KC_ERET;
        end else begin
            kCtrl = KC_NONE;
        end
    end

    assign excInDelaySlot = entry && inDelaySlot;
    assign epc            = epcReg;

    always_comb begin
        case (regNum)
            CP0_SR:    rdData = statusWord;
            CP0_CAUSE: rdData = causeWord;
            CP0_EPC:   rdData = {epcReg, 2'b00};
            CP0_PRID:  rdData = PRID_VALUE;
            default:   rdData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            intMask        <= '1;
            exl            <= 1'b0;
            intEnable      <= 1'b1;
            intPendingBits <= '0;
            causeCode      <= EXC_NONE;
            branchDelay    <= 1'b0;
            epcReg         <= KTEXT_START[31:2];
        end else begin
            // Pending bits simply follow the lines
            intPendingBits <= hwInt;
            if (entry) begin
                exl         <= 1'b1;
                causeCode   <= intPending ? EXC_INT : excIn;
                branchDelay <= inDelaySlot;
                epcReg      <= entryPc[31:2];
            end else if (op == OP_ERET) begin
                exl         <= 1'b0;
                causeCode   <= EXC_NONE;
                branchDelay <= 1'b0;
            end else if (op == OP_MTC0) begin
                if (regNum == CP0_SR) begin
                    intMask   <= wrData[15:10];
                    exl       <= wrData[1];
                    intEnable <= wrData[0];
                end else if (regNum == CP0_EPC) begin
                    epcReg <= wrData[31:2];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dataMemory.sv
//////////////////////////////
// Word-addressed data RAM
// Byte-lane writes on the clock edge, combinational read
// Words outside the array read as zero and ignore writes
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module dataMemory import mipsIsaPkg::*, memMapPkg::*; (
    input  logic   clk,
    input  dmReq_t req,
    output word_t  rdData
);

    word_t               mem [DM_WORDS];
    logic [DM_IDX_W-1:0] idx;
    logic                inRange;

    assign inRange = (req.wordAddr < DM_WORDS);
    assign idx     = req.wordAddr[DM_IDX_W-1:0];

    // Contents start cleared, reset leaves them alone
    initial begin
        for (int i = 0; i < DM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (inRange && req.byteEn[lane]) begin
                mem[idx][8*lane +: 8] <= req.wrData[8*lane +: 8];
            end
        end
    end

    assign rdData = inRange ? mem[idx] : '0;

endmodule

`default_nettype wire

//--- rtl/stageMem.sv
//////////////////////////////
// MEM stage of the pipeline with CP0 and data RAM
// One cycle from memIn to wbOut, no handshake
// Stores are blocked only by memDisable, not by stall
// An incoming exception takes priority over an address fault
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module stageMem import mipsIsaPkg::*, memMapPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        clr,
    input  logic        memDisable,
    input  memStageIn_t memIn,
    input  regAddr_t    wbAddr,
    input  word_t       wbData,
    input  hwInt_t      hwInt,
    output wbStageOut_t wbOut,
    output kernelCtrl_t kCtrl,
    output wordAddr_t   epc,
    output logic        excInDelaySlot
);

    word_t       rtFwd;
    dmReq_t      dmReq;
    byteOffset_t offset;
    excCode_t    addrExc;
    excCode_t    mergedExc;
    word_t       memWord;
    word_t       cp0Data;
    word_t       destData;
    wbStageOut_t wbNext;

    // Write-back forward into the store data, $zero never forwards
    assign rtFwd = ((wbAddr == memIn.rtNum) && (wbAddr != 5'd0)) ? wbData : memIn.rtData;

    memAccessCheck u_memAccessCheck (
        .op        (memIn.op),
        .iclass    (memIn.iclass),
        .addr      (memIn.aluResult),
        .storeData (rtFwd),
        .dmDisable (memDisable),
        .dmReq     (dmReq),
        .offset    (offset),
        .excCode   (addrExc)
    );

    dataMemory u_dataMemory (
        .clk    (clk),
        .req    (dmReq),
        .rdData (memWord)
    );

    assign mergedExc = (memIn.exc != EXC_NONE) ? memIn.exc : addrExc;

    coprocessor0 u_coprocessor0 (
        .clk            (clk),
        .reset          (reset),
        .op             (memIn.op),
        .regNum         (memIn.rdNum),
        .wrData         (rtFwd),
        .pc             (memIn.pc),
        .inDelaySlot    (memIn.delaySlot),
        .hwInt          (hwInt),
        .excIn          (mergedExc),
        .kCtrl          (kCtrl),
        .excInDelaySlot (excInDelaySlot),
        .epc            (epc),
        .rdData         (cp0Data)
    );

    // Destination value for the register file
    always_comb begin
        if (memIn.op == OP_MFC0) begin
            destData = cp0Data;
        end else if (memIn.iclass == CLS_MEM_R) begin
            destData = memWord;
        end else begin
            destData = memIn.destData;
        end
    end

    assign wbNext = '{
        op:       memIn.op,
        iclass:   memIn.iclass,
        pc:       memIn.pc,
        memWord:  memWord,
        offset:   offset,
        destReg:  memIn.destReg,
        destData: destData
    };

    // Write-back pipeline register, all zero is a bubble
    always_ff @(posedge clk) begin
        if (reset || clr) begin
            wbOut <= '0;
        end else if (!stall) begin
            wbOut <= wbNext;
        end
    end

endmodule

`default_nettype wire

//--- verif/stageMem_asserts.sv
//////////////////////////////
// Bound checks on the MEM stage
// All properties sample on the rising clock edge
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module stageMemAsserts import mipsIsaPkg::*, memMapPkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        clr,
    input logic        memDisable,
    input memStageIn_t memIn,
    input dmReq_t      dmReq,
    input kernelCtrl_t kCtrl,
    input wbStageOut_t wbOut
);

    logic storeFault;

    // Store address faults decoded straight from the instruction
    assign storeFault = (memIn.aluResult >= DM_ADDR_END)
        || ((memIn.op == OP_SW) && (memIn.aluResult[1:0] != 2'b00))
        || ((memIn.op == OP_SH) && memIn.aluResult[0]);

    // Only an enabled store without an address fault may drive a lane
    lanesOff: assert property (@(posedge clk) disable iff (reset)
        (memDisable || (memIn.iclass != CLS_MEM_W) || storeFault)
            |-> (dmReq.byteEn == 4'b0000))
        else $error("byte lanes active on a disabled or faulting access");

    noEntryAfterReset: assert property (@(posedge clk)
        reset |=> (kCtrl != KC_ENTRY))
        else $error("kernel entry in the cycle after reset");

    // Clear wins over stall
    holdOnStall: assert property (@(posedge clk) disable iff (reset)
        (stall && !clr) |=> $stable(wbOut))
        else $error("wbOut changed under stall");

endmodule

bind stageMem stageMemAsserts u_stageMemAsserts (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .clr        (clr),
    .memDisable (memDisable),
    .memIn      (memIn),
    .dmReq      (dmReq),
    .kCtrl      (kCtrl),
    .wbOut      (wbOut)
);

`default_nettype wire

//--- verif/stageMemTb.sv
//////////////////////////////
// Testbench for the MEM stage
// Rows are checked against a shadow model of the RAM and CP0
// wbOut of a row is checked one cycle after the row is applied
// Inputs change on the rising edge and outputs are sampled at the falling edge
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module stageMemTb import mipsIsaPkg::*, memMapPkg::*; ();

    localparam int CLK_PERIOD = 8;

    // Row control bits as {memDisable, stall, clr}
    localparam logic [2:0] CTL_NONE  = 3'b000;
    localparam logic [2:0] CTL_CLR   = 3'b001;
    localparam logic [2:0] CTL_STALL = 3'b010;
    localparam logic [2:0] CTL_DIS   = 3'b100;

    typedef struct {
        string       name;
        memStageIn_t in;
        regAddr_t    fwdAddr;
        word_t       fwdData;
        hwInt_t      irq;
        logic [2:0]  ctl;
        kernelCtrl_t expK;
        wordAddr_t   expEpc;
        logic        expDs;
        wbStageOut_t expWb;
    } testRow_t;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        clr;
    logic        memDisable;
    memStageIn_t memIn;
    regAddr_t    wbAddr;
    word_t       wbData;
    hwInt_t      hwInt;
    wbStageOut_t wbOut;
    kernelCtrl_t kCtrl;
    wordAddr_t   epc;
    logic        excInDelaySlot;

    // Shadow state of the reference model
    word_t       shadowMem [DM_WORDS];
    hwInt_t      imSh;
    logic        exlSh;
    logic        ieSh;
    hwInt_t      ipSh;
    excCode_t    codeSh;
    logic        bdSh;
    wordAddr_t   epcSh;
    wbStageOut_t wbSh;

    testRow_t    rows [$];
    int          rowErr [$];
    word_t       lcgState = 32'd45307;
    word_t       nextPc = 32'h0000_0400;
    int          errors = 0;
    int          failedTests = 0;
    logic        tableReady = 1'b0;

    stageMem u_stageMem (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .clr            (clr),
        .memDisable     (memDisable),
        .memIn          (memIn),
        .wbAddr         (wbAddr),
        .wbData         (wbData),
        .hwInt          (hwInt),
        .wbOut          (wbOut),
        .kCtrl          (kCtrl),
        .epc            (epc),
        .excInDelaySlot (excInDelaySlot)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic instrClass_t classOf(instrOp_t op);
        case (op)
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: return CLS_MEM_R;
            OP_SW, OP_SH, OP_SB:                 return CLS_MEM_W;
            OP_MFC0, OP_MTC0, OP_ERET:           return CLS_CP0;
            OP_ALU:                              return CLS_ALU;
            default:                             return CLS_NONE;
        endcase
    endfunction

    function automatic memStageIn_t mkIn(instrOp_t op, word_t addr = '0, regAddr_t rtNum = '0,
                                         word_t rtData = '0, regAddr_t rdNum = '0);
        memStageIn_t m;
        m           = '0;
        m.op        = op;
        m.iclass    = classOf(op);
        m.aluResult = addr;
        m.rtNum     = rtNum;
        m.rtData    = rtData;
        m.rdNum     = rdNum;
        // Loads, MFC0 and ALU ops write r2
        if ((m.iclass == CLS_MEM_R) || (op == OP_MFC0) || (op == OP_ALU)) begin
            m.destReg = 5'd2;
        end
        if (op == OP_ALU) begin
            m.destData = addr;
        end
        return m;
    endfunction

    task automatic addRow(string name, memStageIn_t m, logic [2:0] ctl = CTL_NONE,
                          hwInt_t irq = '0, regAddr_t fwdAddr = '0, word_t fwdData = '0);
        testRow_t r;
        r.name    = name;
        r.in      = m;
        r.in.pc   = nextPc;
        r.fwdAddr = fwdAddr;
        r.fwdData = fwdData;
        r.irq     = irq;
        r.ctl     = ctl;
        r.expK    = KC_NONE;
        r.expEpc  = '0;
        r.expDs   = 1'b0;
        r.expWb   = '0;
        nextPc    = nextPc + 32'd4;
        rows.push_back(r);
        rowErr.push_back(0);
    endtask

    task automatic buildTable();
        memStageIn_t m;
        int          k;
        addRow("sw word", mkIn(OP_SW, 32'h100, 5'd8, nextRand()));
        addRow("lw after sw", mkIn(OP_LW, 32'h100));
        addRow("sh offset 0", mkIn(OP_SH, 32'h104, 5'd8, nextRand()));
        addRow("sh offset 2", mkIn(OP_SH, 32'h106, 5'd8, nextRand()));
        addRow("lw after sh", mkIn(OP_LW, 32'h104));
        for (k = 0; k < 4; k++) begin
            addRow($sformatf("sb offset %0d", k), mkIn(OP_SB, 32'h108 + k, 5'd8, nextRand()));
        end
        addRow("lw after sb", mkIn(OP_LW, 32'h108));
        addRow("sb into word", mkIn(OP_SB, 32'h101, 5'd8, nextRand()));
        addRow("lw merged", mkIn(OP_LW, 32'h100));
        addRow("lbu raw word", mkIn(OP_LBU, 32'h10B));
        addRow("lh raw word", mkIn(OP_LH, 32'h106));
        // Forwarding from write-back into the store data
        addRow("sw forwarded", mkIn(OP_SW, 32'h10C, 5'd9, nextRand()),
               CTL_NONE, '0, 5'd9, nextRand());
        addRow("lw forwarded", mkIn(OP_LW, 32'h10C));
        addRow("sw rt zero", mkIn(OP_SW, 32'h110, 5'd0, nextRand()),
               CTL_NONE, '0, 5'd0, nextRand());
        addRow("lw rt zero", mkIn(OP_LW, 32'h110));
        addRow("sw other rt", mkIn(OP_SW, 32'h114, 5'd10, nextRand()),
               CTL_NONE, '0, 5'd11, nextRand());
        addRow("lw other rt", mkIn(OP_LW, 32'h114));
        // Address faults and the cause they leave
        addRow("lw misaligned", mkIn(OP_LW, 32'h102));
        addRow("mfc0 cause lw", mkIn(OP_MFC0, '0, '0, '0, CP0_CAUSE));
        addRow("eret after lw", mkIn(OP_ERET));
        addRow("lh misaligned", mkIn(OP_LH, 32'h105));
        addRow("mfc0 cause lh", mkIn(OP_MFC0, '0, '0, '0, CP0_CAUSE));
        addRow("eret after lh", mkIn(OP_ERET));
        addRow("lw out of window", mkIn(OP_LW, DM_ADDR_END));
        addRow("mfc0 cause window", mkIn(OP_MFC0, '0, '0, '0, CP0_CAUSE));
        addRow("mfc0 epc window", mkIn(OP_MFC0, '0, '0, '0, CP0_EPC));
        addRow("eret after window", mkIn(OP_ERET));
        addRow("sw before fault", mkIn(OP_SW, 32'h200, 5'd8, nextRand()));
        addRow("sw misaligned", mkIn(OP_SW, 32'h202, 5'd8, nextRand()));
        addRow("mfc0 cause sw", mkIn(OP_MFC0, '0, '0, '0, CP0_CAUSE));
        addRow("eret after sw", mkIn(OP_ERET));
        addRow("lw after fault", mkIn(OP_LW, 32'h200));
        m     = mkIn(OP_ALU, 32'h7FFF_FFFF);
        m.exc = EXC_OV;
        addRow("incoming overflow", m);
        addRow("mfc0 cause ov", mkIn(OP_MFC0, '0, '0, '0, CP0_CAUSE));
        addRow("eret after ov", mkIn(OP_ERET));
        // Interrupts
        addRow("irq entry", mkIn(OP_ALU, 32'h5), CTL_NONE, 6'b000100);
        addRow("irq under exl", mkIn(OP_ALU, 32'h6), CTL_NONE, 6'b000100);
        addRow("mfc0 cause irq", mkIn(OP_MFC0, '0, '0, '0, CP0_CAUSE));
        addRow("mfc0 epc irq", mkIn(OP_MFC0, '0, '0, '0, CP0_EPC));
        addRow("eret after irq", mkIn(OP_ERET));
        m           = mkIn(OP_ALU, 32'h7);
        m.delaySlot = 1'b1;
        addRow("irq in delay slot", m, CTL_NONE, 6'b010000);
        addRow("mfc0 epc slot", mkIn(OP_MFC0, '0, '0, '0, CP0_EPC));
        addRow("eret after slot", mkIn(OP_ERET));
        // CP0 register access
        addRow("mtc0 epc", mkIn(OP_MTC0, '0, 5'd3, 32'h1234_5677, CP0_EPC));
        addRow("mfc0 epc written", mkIn(OP_MFC0, '0, '0, '0, CP0_EPC));
        addRow("mfc0 prid", mkIn(OP_MFC0, '0, '0, '0, CP0_PRID));
        addRow("mtc0 sr ie off", mkIn(OP_MTC0, '0, 5'd3, 32'h0000_FC00, CP0_SR));
        addRow("irq with ie off", mkIn(OP_ALU, 32'h8), CTL_NONE, 6'b100000);
        addRow("mtc0 sr ie on", mkIn(OP_MTC0, '0, 5'd3, 32'h0000_FC01, CP0_SR));
        addRow("mfc0 sr", mkIn(OP_MFC0, '0, '0, '0, CP0_SR));
        // Stall, clear and disabled store
        addRow("alu before stall", mkIn(OP_ALU, 32'hCAFE_0001));
        addRow("stall holds", mkIn(OP_ALU, 32'hCAFE_0002), CTL_STALL);
        addRow("stall holds again", mkIn(OP_ALU, 32'hCAFE_0003), CTL_STALL);
        addRow("clr zeroes", mkIn(OP_ALU, 32'hCAFE_0004), CTL_CLR);
        addRow("alu after clr", mkIn(OP_ALU, 32'hCAFE_0005));
        addRow("sw disabled", mkIn(OP_SW, 32'h100, 5'd8, nextRand()), CTL_DIS);
        addRow("lw after disabled", mkIn(OP_LW, 32'h100));
    endtask

    task automatic initModel();
        for (int i = 0; i < DM_WORDS; i++) begin
            shadowMem[i] = '0;
        end
        imSh   = '1;
        exlSh  = 1'b0;
        ieSh   = 1'b1;
        ipSh   = '0;
        codeSh = EXC_NONE;
        bdSh   = 1'b0;
        epcSh  = KTEXT_START[31:2];
        wbSh   = '0;
    endtask

    // Expected outputs of one row and the state it leaves behind
    task automatic modelRow(int idx);
        testRow_t    r;
        word_t       addr;
        word_t       fwd;
        word_t       rdWord;
        word_t       cp0Val;
        word_t       destVal;
        word_t       entryPc;
        int unsigned wIdx;
        logic [1:0]  off;
        logic        isLoad;
        logic        isStore;
        logic        misal;
        logic        intPend;
        logic        entry;
        excCode_t    addrExc;
        excCode_t    merged;
        wbStageOut_t cand;

        r       = rows[idx];
        addr    = r.in.aluResult;
        off     = addr[1:0];
        wIdx    = {2'b00, addr[31:2]};
        isLoad  = (r.in.iclass == CLS_MEM_R);
        isStore = (r.in.iclass == CLS_MEM_W);
        fwd     = ((r.fwdAddr == r.in.rtNum) && (r.fwdAddr != 5'd0)) ? r.fwdData : r.in.rtData;

        // Words need offset 0 and halfwords an even offset
        case (r.in.op)
            OP_LW, OP_SW:         misal = (off != 2'b00);
            OP_LH, OP_LHU, OP_SH: misal = off[0];
            default:              misal = 1'b0;
        endcase
        addrExc = EXC_NONE;
        if ((isLoad || isStore) && (misal || (addr >= DM_ADDR_END))) begin
            addrExc = isLoad ? EXC_ADEL : EXC_ADES;
        end
        merged = (r.in.exc != EXC_NONE) ? r.in.exc : addrExc;
        rdWord = (wIdx < DM_WORDS) ? shadowMem[wIdx] : '0;

        case (r.in.rdNum)
            CP0_SR:    cp0Val = {16'b0, imSh, 8'b0, exlSh, ieSh};
            CP0_CAUSE: cp0Val = {bdSh, 15'b0, ipSh, 3'b0, codeSh, 2'b0};
            CP0_EPC:   cp0Val = {epcSh, 2'b00};
            CP0_PRID:  cp0Val = PRID_VALUE;
            default:   cp0Val = '0;
        endcase

        intPend  = (|(imSh & r.irq)) && ieSh && !exlSh;
        entry    = intPend || (merged != EXC_NONE);
        r.expK   = entry ? KC_ENTRY : ((r.in.op == OP_ERET) ? KC_ERET : KC_NONE);
        r.expDs  = entry && r.in.delaySlot;
        r.expEpc = epcSh;

        if (r.in.op == OP_MFC0) begin
            destVal = cp0Val;
        end else if (isLoad) begin
            destVal = rdWord;
        end else begin
            destVal = r.in.destData;
        end
        cand = '{op: r.in.op, iclass: r.in.iclass, pc: r.in.pc, memWord: rdWord,
                 offset: off, destReg: r.in.destReg, destData: destVal};
        if (r.ctl[0]) begin
            wbSh = '0;
        end else if (!r.ctl[1]) begin
            wbSh = cand;
        end
        r.expWb = wbSh;

        // Stores land only when enabled and free of an address fault
        if (isStore && !r.ctl[2] && (addrExc == EXC_NONE) && (wIdx < DM_WORDS)) begin
            case (r.in.op)
                OP_SW: shadowMem[wIdx] = fwd;
                OP_SH: begin
                    if (off[1]) begin
                        shadowMem[wIdx][31:16] = fwd[15:0];
                    end else begin
                        shadowMem[wIdx][15:0] = fwd[15:0];
                    end
                end
                OP_SB:   shadowMem[wIdx][{off, 3'b000} +: 8] = fwd[7:0];
                default: ;
            endcase
        end

        entryPc = r.in.delaySlot ? (r.in.pc - 32'd4) : r.in.pc;
        ipSh    = r.irq;
        if (entry) begin
            exlSh  = 1'b1;
            codeSh = intPend ? EXC_NONE : merged;
            bdSh   = r.in.delaySlot;
            epcSh  = entryPc[31:2];
        end else if (r.in.op == OP_ERET) begin
            exlSh  = 1'b0;
            codeSh = EXC_NONE;
            bdSh   = 1'b0;
        end else if ((r.in.op == OP_MTC0) && (r.in.rdNum == CP0_SR)) begin
            imSh  = fwd[15:10];
            exlSh = fwd[1];
            ieSh  = fwd[0];
        end else if ((r.in.op == OP_MTC0) && (r.in.rdNum == CP0_EPC)) begin
            epcSh = fwd[31:2];
        end
        rows[idx] = r;
    endtask

    task automatic driveRow(int idx);
        memIn      <= rows[idx].in;
        wbAddr     <= rows[idx].fwdAddr;
        wbData     <= rows[idx].fwdData;
        hwInt      <= rows[idx].irq;
        memDisable <= rows[idx].ctl[2];
        stall      <= rows[idx].ctl[1];
        clr        <= rows[idx].ctl[0];
    endtask

    task automatic reportMismatch(int idx, string what, logic [127:0] expVal,
                                  logic [127:0] actVal);
        $display("** Error %s %s: expected 0x%0h actual 0x%0h",
                 rows[idx].name, what, expVal, actVal);
        errors      = errors + 1;
        rowErr[idx] = rowErr[idx] + 1;
    endtask

    task automatic checkComb(int idx);
        if (kCtrl !== rows[idx].expK) begin
            reportMismatch(idx, "kCtrl", 128'(rows[idx].expK), 128'(kCtrl));
        end
        if (epc !== rows[idx].expEpc) begin
            reportMismatch(idx, "epc", 128'(rows[idx].expEpc), 128'(epc));
        end
        if (excInDelaySlot !== rows[idx].expDs) begin
            reportMismatch(idx, "excInDelaySlot", 128'(rows[idx].expDs), 128'(excInDelaySlot));
        end
    endtask

    // Closes a row with its result line
    task automatic checkWb(int idx);
        if (wbOut !== rows[idx].expWb) begin
            reportMismatch(idx, "wbOut", 128'(rows[idx].expWb), 128'(wbOut));
        end
        if (rowErr[idx] == 0) begin
            $display("ok    %s", rows[idx].name);
        end else begin
            $display("bad   %s (%0d mismatches)", rows[idx].name, rowErr[idx]);
            failedTests = failedTests + 1;
        end
    endtask

    initial begin
        reset      = 1'b1;
        stall      = 1'b0;
        clr        = 1'b0;
        memDisable = 1'b0;
        memIn      = '0;
        wbAddr     = '0;
        wbData     = '0;
        hwInt      = '0;
        initModel();
        buildTable();
        for (int i = 0; i < rows.size(); i++) begin
            modelRow(i);
        end
        tableReady = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            driveRow(i);
            @(negedge clk);
            if (i > 0) begin
                checkWb(i - 1);
            end
            checkComb(i);
        end
        // Bubble so the last row reaches wbOut
        @(posedge clk);
        memIn <= '0;
        stall <= 1'b0;
        clr   <= 1'b0;
        hwInt <= '0;
        @(negedge clk);
        checkWb(rows.size() - 1);
        $display("Summary: %0d tests, %0d failed, %0d mismatches",
                 rows.size(), failedTests, errors);
        if (failedTests == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog of four cycles per row plus a margin
    initial begin
        wait (tableReady);
        repeat (rows.size() * 4 + 20) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", rows.size() * 4 + 20);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- stageMem.f
rtl/mipsIsaPkg.sv
rtl/memMapPkg.sv
rtl/memAccessCheck.sv
rtl/coprocessor0.sv
rtl/dataMemory.sv
rtl/stageMem.sv
verif/stageMem_asserts.sv
verif/stageMemTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the MEM stage testbench with Verilator and run it
# The run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module stageMemTb -f stageMem.f \
    -o stageMemSim > build.log 2>&1 \
    && ./obj_dir/stageMemSim > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
